//--- src/icache_pkg.sv
package icache_pkg;

    localparam int TAG_BITS       = 20;
    localparam int INDEX_BITS     = 7;
    localparam int OFFSET_BITS    = 5;
    localparam int WORDS_PER_LINE = 8;
    localparam int SETS           = 128;

    localparam logic [2:0] UNCACHED_BASE = 3'b101;  // top address bits of io space

    typedef logic [31:0] word_t;
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;  // word 0 in low bits
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;

    typedef enum logic [2:0] {
        idle,
        miss_a,
        miss_b,
        refill_wait,  // re-read after the last fill
        uncached_wait
    } cache_state_t;

    function automatic tag_t addr_tag(word_t a);
        return a[31 -: TAG_BITS];
    endfunction

    function automatic index_t addr_index(word_t a);
        return a[OFFSET_BITS +: INDEX_BITS];
    endfunction

    function automatic logic [2:0] addr_word(word_t a);
        return a[OFFSET_BITS-1:2];
    endfunction

    function automatic logic is_uncached(word_t a);
        return a[31:29] == UNCACHED_BASE;
    endfunction

endpackage

//--- src/fetch_if.sv
`timescale 1ns/1ps

interface fetch_if;
    import icache_pkg::*;

    word_t       pc;
    logic        req;
    logic        hold;        // consumer stalled, keep result
    logic        flush;       // redirect
    logic        stall;
    word_t [1:0] inst;
    logic  [1:0] inst_valid;

    modport fetch (
        output pc,
        output req,
        output hold,
        output flush,
        input  stall,
        input  inst,
        input  inst_valid
    );

    modport cache (
        input  pc,
        input  req,
        input  hold,
        input  flush,
        output stall,
        output inst,
        output inst_valid
    );

endinterface

//--- src/icache_way_ram.sv
`timescale 1ns/1ps

module icache_way_ram (
    input  logic               clk,
    input  logic               we,
    input  icache_pkg::index_t addr_a,
    input  icache_pkg::line_t  wdata,
    input  icache_pkg::tag_t   wtag,
    output icache_pkg::line_t  rdata_a,
    output icache_pkg::tag_t   rtag_a,
    output logic               rvalid_a,
    input  icache_pkg::index_t addr_b,
    output icache_pkg::line_t  rdata_b,
    output icache_pkg::tag_t   rtag_b,
    output logic               rvalid_b,
    input  logic               reset
);
    import icache_pkg::*;

    word_t           bank [WORDS_PER_LINE][SETS];
    tag_t            tag_mem [SETS];
    logic [SETS-1:0] valid_bits;

    // one bank per word, whole line written at once
    always_ff @(posedge clk) begin
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (we) begin
                bank[w][addr_a] <= wdata[w*32 +: 32];
            end
            rdata_a[w*32 +: 32] <= bank[w][addr_a];  // old data on collision
            rdata_b[w*32 +: 32] <= bank[w][addr_b];
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[addr_a] <= wtag;
        end
        rtag_a <= tag_mem[addr_a];
        rtag_b <= tag_mem[addr_b];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            rvalid_a   <= 1'b0;
            rvalid_b   <= 1'b0;
        end else begin
            if (we) begin
                valid_bits[addr_a] <= 1'b1;
            end
            rvalid_a <= valid_bits[addr_a];
            rvalid_b <= valid_bits[addr_b];
        end
    end

endmodule

//--- src/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic              clk,
    input  logic              reset,
    fetch_if.cache            fif,
    output logic              rd_req,
    output icache_pkg::word_t rd_addr,
    input  logic              ret_valid,
    input  icache_pkg::line_t ret_data,
    output logic              uc_req,
    output icache_pkg::word_t uc_addr,
    input  logic              uc_valid,
    input  icache_pkg::word_t uc_data
);
    import icache_pkg::*;

    cache_state_t    state;
    cache_state_t    state_next;
    word_t           addr_a_q;
    word_t           addr_b_q;
    word_t           pc_b;
    word_t           uc_word_q;
    logic            pend_q;      // accepted pair not yet consumed
    logic            b_miss_q;
    logic            uc_done_q;
    logic [SETS-1:0] lru;         // 1 means way1 is the victim

    line_t  w0_data_a;
    line_t  w0_data_b;
    line_t  w1_data_a;
    line_t  w1_data_b;
    tag_t   w0_tag_a;
    tag_t   w0_tag_b;
    tag_t   w1_tag_a;
    tag_t   w1_tag_b;
    logic   w0_valid_a;
    logic   w0_valid_b;
    logic   w1_valid_a;
    logic   w1_valid_b;

    index_t ram_addr_a;
    index_t ram_addr_b;
    index_t fill_index;
    tag_t   fill_tag;
    logic   fill;
    logic   victim;
    logic   uc_q;
    logic   same_line;
    logic   lookup;
    logic   hit_a0;
    logic   hit_a1;
    logic   hit_b0;
    logic   hit_b1;
    logic   hit_a;
    logic   hit_b;
    logic   present_line;
    logic   present_uc;
    logic   accept_slot;

    assign pc_b      = fif.pc + 32'd4;
    assign uc_q      = is_uncached(addr_a_q);
    assign same_line = addr_a_q[31:OFFSET_BITS] == addr_b_q[31:OFFSET_BITS];
    assign lookup    = state == idle && pend_q && !uc_q;

    assign hit_a0 = w0_valid_a && w0_tag_a == addr_tag(addr_a_q);
    assign hit_a1 = w1_valid_a && w1_tag_a == addr_tag(addr_a_q);
    assign hit_b0 = w0_valid_b && w0_tag_b == addr_tag(addr_b_q);
    assign hit_b1 = w1_valid_b && w1_tag_b == addr_tag(addr_b_q);
    assign hit_a  = hit_a0 || hit_a1;
    assign hit_b  = hit_b0 || hit_b1;

    assign present_line = lookup && hit_a && hit_b;
    assign present_uc   = state == idle && pend_q && uc_q && uc_done_q;
    assign fif.stall    = state != idle || (pend_q && !(present_line || present_uc));
    assign accept_slot  = !fif.stall && !fif.hold;

    // refill target: line of a in miss_a, line of b in miss_b
    assign fill_index = state == miss_b ? addr_index(addr_b_q) : addr_index(addr_a_q);
    assign fill_tag   = state == miss_b ? addr_tag(addr_b_q) : addr_tag(addr_a_q);
    assign fill       = ret_valid && (state == miss_a || state == miss_b);
    assign victim     = lru[fill_index];

    always_comb begin
        if (state == miss_a || state == miss_b) begin
            ram_addr_a = fill_index;
        end else if (accept_slot) begin
            ram_addr_a = addr_index(fif.pc);
        end else begin
            ram_addr_a = addr_index(addr_a_q);  // re-read held or refilled pair
        end
        ram_addr_b = accept_slot ? addr_index(pc_b) : addr_index(addr_b_q);
    end

    icache_way_ram way0_i (
        .clk      (clk),
        .we       (fill && !victim),
        .addr_a   (ram_addr_a),
        .wdata    (ret_data),
        .wtag     (fill_tag),
        .rdata_a  (w0_data_a),
        .rtag_a   (w0_tag_a),
        .rvalid_a (w0_valid_a),
        .addr_b   (ram_addr_b),
        .rdata_b  (w0_data_b),
        .rtag_b   (w0_tag_b),
        .rvalid_b (w0_valid_b),
        .reset    (reset)
    );

    icache_way_ram way1_i (
        .clk      (clk),
        .we       (fill && victim),
        .addr_a   (ram_addr_a),
        .wdata    (ret_data),
        .wtag     (fill_tag),
        .rdata_a  (w1_data_a),
        .rtag_a   (w1_tag_a),
        .rvalid_a (w1_valid_a),
        .addr_b   (ram_addr_b),
        .rdata_b  (w1_data_b),
        .rtag_b   (w1_tag_b),
        .rvalid_b (w1_valid_b),
        .reset    (reset)
    );

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (pend_q && uc_q && !uc_done_q) begin
                    state_next = uncached_wait;
                end else if (lookup && !hit_a) begin
                    state_next = miss_a;
                end else if (lookup && !hit_b) begin
                    state_next = miss_b;
                end
            end
            miss_a: begin
                if (ret_valid) begin
                    if (!pend_q || fif.flush) begin
                        state_next = idle;  // killed, line written only
                    end else if (b_miss_q) begin
                        state_next = miss_b;
                    end else begin
                        state_next = refill_wait;
                    end
                end
            end
            miss_b: begin
                if (ret_valid) begin
                    state_next = (!pend_q || fif.flush) ? idle : refill_wait;
                end
            end
            refill_wait: state_next = idle;
            uncached_wait: begin
                if (uc_valid) begin
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
        if (fif.flush && (state == idle || state == refill_wait)) begin
            state_next = idle;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= idle;
            pend_q    <= 1'b0;
            uc_done_q <= 1'b0;
            b_miss_q  <= 1'b0;
        end else begin
            state <= state_next;
            if (fif.flush) begin
                pend_q    <= 1'b0;
                uc_done_q <= 1'b0;
            end else if (accept_slot) begin
                pend_q    <= fif.req;
                uc_done_q <= 1'b0;
            end else if (state == uncached_wait && uc_valid) begin
                uc_done_q <= pend_q;
            end
            if (lookup) begin
                b_miss_q <= !hit_b && !same_line;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept_slot) begin
            addr_a_q <= fif.pc;
            addr_b_q <= pc_b;
        end
        if (state == uncached_wait && uc_valid) begin
            uc_word_q <= uc_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (fill) begin
            lru[fill_index] <= !victim;
        end else if (lookup) begin
            if (hit_a) begin
                lru[addr_index(addr_a_q)] <= hit_a0;
            end
            if (hit_b) begin
                lru[addr_index(addr_b_q)] <= hit_b0;
            end
        end
    end

    always_comb begin
        fif.inst[0] = hit_a0 ? w0_data_a[addr_word(addr_a_q)*32 +: 32]
                             : w1_data_a[addr_word(addr_a_q)*32 +: 32];
        fif.inst[1] = hit_b0 ? w0_data_b[addr_word(addr_b_q)*32 +: 32]
                             : w1_data_b[addr_word(addr_b_q)*32 +: 32];
        fif.inst_valid = 2'b00;
        if (present_uc) begin
            fif.inst[0]    = uc_word_q;
            fif.inst_valid = 2'b01;  // one word only
        end else if (present_line) begin
            fif.inst_valid = 2'b11;
        end
    end

    assign rd_req  = state == miss_a || state == miss_b;
    assign rd_addr = {fill_tag, fill_index, {OFFSET_BITS{1'b0}}};
    assign uc_req  = state == uncached_wait;
    assign uc_addr = addr_a_q;

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic              clk,
    input  logic              reset,
    fetch_if.fetch            fif,
    input  logic              redirect,
    input  icache_pkg::word_t redirect_pc,
    input  logic              out_ready,
    output logic              out_valid,
    output icache_pkg::word_t out_pc,
    output icache_pkg::word_t out_inst0,
    output icache_pkg::word_t out_inst1,
    output logic [1:0]        out_count
);
    import icache_pkg::*;

    word_t      pc_q;
    word_t      flight_pc_q;  // pc of the pair in the cache
    logic [1:0] word_count;
    logic       issue;

    assign fif.pc    = pc_q;
    assign fif.req   = !redirect;
    assign fif.hold  = !out_ready;
    assign fif.flush = redirect;
    assign issue     = fif.req && !fif.stall && !fif.hold;

    // words this request returns, one in the uncached region
    assign word_count = is_uncached(pc_q) ? 2'd1 : 2'd2;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= '0;
        end else if (redirect) begin
            pc_q <= redirect_pc;
        end else if (issue) begin
            pc_q <= pc_q + {28'd0, word_count, 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            flight_pc_q <= pc_q;
        end
    end

    assign out_valid = (|fif.inst_valid) && !redirect;  // old path dropped
    assign out_pc    = flight_pc_q;
    assign out_inst0 = fif.inst[0];
    assign out_inst1 = fif.inst[1];
    assign out_count = fif.inst_valid[1] ? 2'd2 : 2'd1;

endmodule

//--- src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              redirect,
    input  icache_pkg::word_t redirect_pc,
    input  logic              out_ready,
    output logic              out_valid,
    output icache_pkg::word_t out_pc,
    output icache_pkg::word_t out_inst0,
    output icache_pkg::word_t out_inst1,
    output logic [1:0]        out_count,
    output logic              rd_req,
    output icache_pkg::word_t rd_addr,
    input  logic              ret_valid,
    input  icache_pkg::line_t ret_data,
    output logic              uc_req,
    output icache_pkg::word_t uc_addr,
    input  logic              uc_valid,
    input  icache_pkg::word_t uc_data
);

    fetch_if fetch_bus ();

    fetch_unit fetch_i (
        .clk         (clk),
        .reset       (reset),
        .fif         (fetch_bus.fetch),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_inst0   (out_inst0),
        .out_inst1   (out_inst1),
        .out_count   (out_count)
    );

    icache icache_i (
        .clk       (clk),
        .reset     (reset),
        .fif       (fetch_bus.cache),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .uc_req    (uc_req),
        .uc_addr   (uc_addr),
        .uc_valid  (uc_valid),
        .uc_data   (uc_data)
    );

endmodule

//--- dv/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    localparam logic [31:0] MEM_XOR   = 32'h3c00_0000;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic         clk;
    logic         reset       = 1'b1;
    logic         redirect    = 1'b0;
    logic [31:0]  redirect_pc = 32'd0;
    logic         out_ready   = 1'b1;
    logic         out_valid;
    logic [31:0]  out_pc;
    logic [31:0]  out_inst0;
    logic [31:0]  out_inst1;
    logic [1:0]   out_count;
    logic         rd_req;
    logic [31:0]  rd_addr;
    logic         ret_valid   = 1'b0;
    logic [255:0] ret_data    = '0;
    logic         uc_req;
    logic [31:0]  uc_addr;
    logic         uc_valid    = 1'b0;
    logic [31:0]  uc_data     = 32'd0;

    string        step_name [$];
    logic [31:0]  step_addr [$];
    int           step_pairs [$];
    int           step_misses [$];

    logic [31:0]  lfsr        = 32'h9c6614d8;
    logic         refill_busy = 1'b0;
    int           refill_delay;
    logic [31:0]  refill_addr;
    logic         uc_busy     = 1'b0;
    int           uc_delay;
    logic [31:0]  uc_addr_q;

    string        cur_name    = "reset";
    logic [31:0]  expect_pc;
    int           pairs_left  = 0;
    logic         counting    = 1'b0;
    int           miss_count  = 0;
    int           uc_count    = 0;
    logic         rd_req_prev = 1'b0;
    logic [31:0]  rd_addr_prev;
    logic         uc_req_prev = 1'b0;
    logic [31:0]  uc_addr_prev;
    logic         held        = 1'b0;
    logic [31:0]  held_pc;
    logic [31:0]  held_inst0;
    logic [31:0]  held_inst1;
    logic [1:0]   held_count;
    int           limit_cycles = 0;

    fetch_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_inst0   (out_inst0),
        .out_inst1   (out_inst1),
        .out_count   (out_count),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .ret_valid   (ret_valid),
        .ret_data    (ret_data),
        .uc_req      (uc_req),
        .uc_addr     (uc_addr),
        .uc_valid    (uc_valid),
        .uc_data     (uc_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h actual %h",
                                what, expected, actual));
        end
    endtask

    // galois step for every bit taken
    function automatic int take_bits(input int count);
        int value;
        value = 0;
        for (int k = 0; k < count; k++) begin
            lfsr  = lfsr[0] ? (lfsr >> 1) ^ LFSR_TAPS : lfsr >> 1;
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic logic in_uncached_region(input logic [31:0] addr);
        return addr[31:29] == 3'b101;
    endfunction

    function automatic logic [255:0] line_data(input logic [31:0] base);
        logic [255:0] data;
        for (int w = 0; w < 8; w++) begin
            data[w*32 +: 32] = (base + w * 4) ^ MEM_XOR;
        end
        return data;
    endfunction

    // refill memory, uncached port and consumer back-pressure
    always @(posedge clk) begin
        int bits;
        ret_valid <= 1'b0;
        uc_valid  <= 1'b0;
        if (reset) begin
            refill_busy <= 1'b0;
            uc_busy     <= 1'b0;
            out_ready   <= 1'b1;
        end else begin
            bits = take_bits(2);
            out_ready <= bits != 3;  // low about one cycle in four
            if (refill_busy) begin
                if (refill_delay == 0) begin
                    ret_valid   <= 1'b1;
                    ret_data    <= line_data(refill_addr);
                    refill_busy <= 1'b0;
                end else begin
                    refill_delay <= refill_delay - 1;
                end
            end else if (rd_req && !ret_valid) begin
                bits = take_bits(3);
                refill_delay <= bits;  // 1 to 8 cycles to ret_valid
                refill_addr  <= rd_addr;
                refill_busy  <= 1'b1;
            end
            if (uc_busy) begin
                if (uc_delay == 0) begin
                    uc_valid <= 1'b1;
                    uc_data  <= ~uc_addr_q;
                    uc_busy  <= 1'b0;
                end else begin
                    uc_delay <= uc_delay - 1;
                end
            end else if (uc_req && !uc_valid) begin
                bits = take_bits(3);
                uc_delay  <= bits;
                uc_addr_q <= uc_addr;
                uc_busy   <= 1'b1;
            end
        end
    end

    task automatic check_pair();
        logic [31:0] exp_count;
        logic [31:0] exp_inst0;
        exp_count = in_uncached_region(expect_pc) ? 32'd1 : 32'd2;
        exp_inst0 = in_uncached_region(expect_pc) ? ~expect_pc : expect_pc ^ MEM_XOR;
        check_value($sformatf("%s out_pc", cur_name), expect_pc, out_pc);
        check_value($sformatf("%s out_count", cur_name), exp_count, {30'd0, out_count});
        check_value($sformatf("%s out_inst0", cur_name), exp_inst0, out_inst0);
        if (exp_count == 32'd2) begin
            check_value($sformatf("%s out_inst1", cur_name), (expect_pc + 32'd4) ^ MEM_XOR,
                        out_inst1);
        end
        expect_pc  = expect_pc + exp_count * 4;
        pairs_left = pairs_left - 1;
        if (pairs_left == 0) begin
            counting = 1'b0;
        end
    endtask

    // one cycle sampled at the falling edge
    task automatic sample_cycle();
        @(negedge clk);
        if (counting && rd_req && (!rd_req_prev || rd_addr != rd_addr_prev)) begin
            miss_count = miss_count + 1;
        end
        if (counting && uc_req && (!uc_req_prev || uc_addr != uc_addr_prev)) begin
            uc_count = uc_count + 1;
        end
        rd_req_prev  = rd_req;
        rd_addr_prev = rd_addr;
        uc_req_prev  = uc_req;
        uc_addr_prev = uc_addr;
        if (held && !redirect) begin
            check_value($sformatf("%s held out_valid", cur_name), 32'd1, {31'd0, out_valid});
            check_value($sformatf("%s held out_pc", cur_name), held_pc, out_pc);
            check_value($sformatf("%s held out_inst0", cur_name), held_inst0, out_inst0);
            if (held_count == 2'd2) begin
                check_value($sformatf("%s held out_inst1", cur_name), held_inst1, out_inst1);
            end
        end
        held       = out_valid && !out_ready && !redirect;
        held_pc    = out_pc;
        held_inst0 = out_inst0;
        held_inst1 = out_inst1;
        held_count = out_count;
        if (pairs_left > 0 && out_valid && out_ready) begin
            check_pair();
        end
    endtask

    task automatic load_steps();
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] addr;
        int          pairs;
        int          misses;
        fd = $fopen("dv/fetch_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file dv/fetch_stimulus.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %h %d %d", name, addr, pairs, misses);
                    if (n != 4) begin
                        abort_run($sformatf("malformed stimulus line: %s", line));
                    end else begin
                        step_name.push_back(name);
                        step_addr.push_back(addr);
                        step_pairs.push_back(pairs);
                        step_misses.push_back(misses);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_step(input int i);
        logic [31:0] line_base;
        cur_name   = step_name[i];
        line_base  = {step_addr[i][31:5], 5'd0};
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= step_addr[i];
        expect_pc   = step_addr[i];
        pairs_left  = step_pairs[i];
        miss_count  = 0;
        uc_count    = 0;
        sample_cycle();
        @(posedge clk);
        redirect <= 1'b0;
        if (step_pairs[i] == 0) begin
            sample_cycle();
            while (!(rd_req && rd_addr == line_base)) begin
                sample_cycle();  // until this path's refill is pending
            end
        end else begin
            counting = 1'b1;
            while (pairs_left > 0) begin
                sample_cycle();
            end
            check_value($sformatf("%s refill count", cur_name), step_misses[i], miss_count);
            check_value($sformatf("%s uncached count", cur_name),
                        in_uncached_region(step_addr[i]) ? step_pairs[i] : 0, uc_count);
        end
    endtask

    initial begin
        int total_pairs;
        total_pairs = 0;
        load_steps();
        foreach (step_pairs[i]) begin
            total_pairs = total_pairs + step_pairs[i];
        end
        limit_cycles = 200 * (total_pairs + step_name.size()) + 100;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        sample_cycle();
        check_value("reset out_valid", 32'd0, {31'd0, out_valid});
        check_value("reset rd_req", 32'd0, {31'd0, rd_req});
        check_value("reset uc_req", 32'd0, {31'd0, uc_req});
        for (int i = 0; i < step_name.size(); i++) begin
            run_step(i);
        end
        $display("TEST OK");
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        abort_run("timeout: the DUT stopped delivering fetched pairs");
    end

endmodule

//--- build.f
src/icache_pkg.sv
src/fetch_if.sv
src/icache_way_ram.sv
src/icache.sv
src/fetch_unit.sv
src/fetch_top.sv
dv/fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module fetch_tb -Mdir obj_dir -o fetch_sim -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/fetch_sim 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "TEST OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- dv/fetch_stimulus.txt
# columns: test name, redirect address (hex), pairs to collect, expected refill count
# zero pairs: start that path, then leave it by redirect while its refill is pending
cold_seq      00001000 8 2
reuse_seq     00001000 8 0
second_line   00002000 4 1
two_per_set   00001000 4 0
lru_x_fill    00003200 1 1
lru_y_fill    00004200 1 1
lru_x_touch   00003200 1 0
lru_z_fill    00005200 1 1
lru_x_kept    00003200 1 0
lru_y_evict   00004200 1 1
cross_line    0000881c 3 2
uncached      a0000100 4 0
miss_abandon  00006400 0 0
miss_redirect 00007600 4 1
reuse_after   00007600 4 0
long_seq      00010800 16 4
